//--- tb.f
+incdir+tests
design/corr_cfg_pkg.sv
design/corr_data_pkg.sv
design/sample_delay_line.sv
design/lag_accumulator.sv
design/correlator_core.sv
design/count_readout.sv
design/correlator_top.sv
tests/tb_correlator.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f tb.f --top-module tb_correlator -Mdir obj_dir

# a failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/Vtb_correlator

//--- tests/tb_vectors.svh
//**************************************************
// stimulus table, samples with repeats and clears
//**************************************************

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per step with four input samples and a strobe count
// clr pulses clear before the row and rnd swaps in generated samples
typedef struct packed {
	int s0;
	int s1;
	int s2;
	int s3;
	int reps;
	bit clr;
	bit rnd;
} step_t;

localparam int NUM_STEPS = 15;

localparam step_t STEPS [NUM_STEPS] = '{
	'{ 0,  0,  0,  0,   0, 1'b0, 1'b0},
	// impulse on the lagged side, then on input 0
	'{ 0, -1,  1, -2,   1, 1'b0, 1'b0},
	'{ 0,  0,  0,  0,   1, 1'b0, 1'b0},
	'{ 1,  0,  0,  0,   1, 1'b0, 1'b0},
	'{ 0,  0,  0,  0,   4, 1'b0, 1'b0},
	// mixed table and generated samples
	'{ 1, -1,  0, -2,   3, 1'b1, 1'b0},
	'{ 0,  0,  0,  0,  40, 1'b0, 1'b1},
	'{-1,  1, -2,  1,   2, 1'b0, 1'b0},
	'{ 0,  0,  0,  0,  60, 1'b0, 1'b1},
	// every lag runs past the accumulator limit
	'{-2, -2, -2, -2, 600, 1'b1, 1'b0},
	'{-2, -2, -2, -2,  20, 1'b0, 1'b0},
	'{ 0,  0,  0,  0,  30, 1'b0, 1'b1},
	// restart from zero after a clear
	'{ 0,  0,  0,  0,   0, 1'b1, 1'b0},
	'{ 0,  0,  0,  0,  50, 1'b0, 1'b1},
	'{ 1,  1, -1, -1,   5, 1'b0, 1'b0}
};

`endif

//--- tests/tb_correlator.sv
//**************************************************
// correlator testbench, reference model and readback
//**************************************************

module tb_correlator;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INPUTS = 4;
	localparam int SAMPLE_WIDTH = 2;
	localparam int NUM_LAGS = 3;
	localparam int ACC_WIDTH = 12;
	localparam int COUNTS = NUM_INPUTS * (NUM_INPUTS - 1) / 2 * NUM_LAGS;
	localparam int ADDR_WIDTH = $clog2(COUNTS);
	localparam int ACC_HI = 2 ** (ACC_WIDTH - 1) - 1;
	localparam int ACC_LO = -(2 ** (ACC_WIDTH - 1));

	`include "tb_vectors.svh"

	logic pllclk;
	logic reset;
	logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] samples;
	logic smpclk;
	logic clear;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic rd_strobe;
	logic signed [ACC_WIDTH-1:0] rd_real;
	logic signed [ACC_WIDTH-1:0] rd_imag;
	logic rd_overflow;
	logic rd_valid;

	// reference model history with tap 0 newest
	int hist [NUM_INPUTS][NUM_LAGS+1];
	int model_real [COUNTS];
	int model_imag [COUNTS];
	bit model_ovf [COUNTS];
	logic [31:0] lcg_state;

	correlator_top #(
		.NUM_INPUTS(NUM_INPUTS),
		.SAMPLE_WIDTH(SAMPLE_WIDTH),
		.NUM_LAGS(NUM_LAGS),
		.ACC_WIDTH(ACC_WIDTH)
	) dut (.*);

	initial begin
		pllclk = 1'b0;
		forever #50 pllclk = ~pllclk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int to_sample(input logic [SAMPLE_WIDTH-1:0] bits);
		logic signed [SAMPLE_WIDTH-1:0] value;
		value = bits;
		return int'(value);
	endfunction

	task automatic model_clear();
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int t = 0; t <= NUM_LAGS; t++) begin
				hist[i][t] = 0;
			end
		end
		for (int c = 0; c < COUNTS; c++) begin
			model_real[c] = 0;
			model_imag[c] = 0;
			model_ovf[c] = 1'b0;
		end
	endtask

	task automatic model_strobe(input logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] bus);
		int addr;
		int sum_re;
		int sum_im;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int t = NUM_LAGS; t > 0; t--) begin
				hist[i][t] = hist[i][t-1];
			end
			hist[i][0] = to_sample(bus[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
		end
		// pairs in row order, lags innermost
		addr = 0;
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					sum_re = model_real[addr] + hist[a][0] * hist[b][k];
					sum_im = model_imag[addr] + hist[a][0] * hist[b][k+1];
					if (!model_ovf[addr]) begin
						if (sum_re > ACC_HI || sum_re < ACC_LO || sum_im > ACC_HI ||
								sum_im < ACC_LO) begin
							model_ovf[addr] = 1'b1;
						end else begin
							model_real[addr] = sum_re;
							model_imag[addr] = sum_im;
						end
					end
					addr++;
				end
			end
		end
	endtask

	// one strobe every 3 cycles
	task automatic apply_strobe(input logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] bus);
		@(negedge pllclk);
		samples = bus;
		smpclk = 1'b1;
		model_strobe(bus);
		@(negedge pllclk);
		smpclk = 1'b0;
		@(negedge pllclk);
	endtask

	task automatic pulse_clear();
		@(negedge pllclk);
		clear = 1'b1;
		model_clear();
		@(negedge pllclk);
		clear = 1'b0;
	endtask

	task automatic read_and_check(input int addr);
		int exp_real;
		int exp_imag;
		bit exp_ovf;
		exp_real = (addr < COUNTS) ? model_real[addr] : 0;
		exp_imag = (addr < COUNTS) ? model_imag[addr] : 0;
		exp_ovf = (addr < COUNTS) ? model_ovf[addr] : 1'b0;
		@(negedge pllclk);
		assert (rd_valid == 1'b0)
			else stop_with_failure("rd_valid stayed high longer than one cycle");
		rd_addr = ADDR_WIDTH'(addr);
		rd_strobe = 1'b1;
		@(negedge pllclk);
		rd_strobe = 1'b0;
		assert (rd_valid == 1'b1) else stop_with_failure($sformatf(
			"rd_valid did not follow rd_strobe one cycle later at address %0d", addr));
		assert (rd_real == exp_real) else stop_with_failure($sformatf(
			"error at %0d ns: rd_real at address %0d expected %0d, got %0d",
			$time, addr, exp_real, rd_real));
		assert (rd_imag == exp_imag) else stop_with_failure($sformatf(
			"error at %0d ns: rd_imag at address %0d expected %0d, got %0d",
			$time, addr, exp_imag, rd_imag));
		assert (rd_overflow == exp_ovf) else stop_with_failure($sformatf(
			"error at %0d ns: rd_overflow at address %0d expected %0d, got %0d",
			$time, addr, exp_ovf, rd_overflow));
	endtask

	initial begin
		logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] bus;
		reset = 1'b0;
		samples = '0;
		smpclk = 1'b0;
		clear = 1'b0;
		rd_addr = '0;
		rd_strobe = 1'b0;
		lcg_state = 32'he3bc;
		model_clear();
		repeat (5) @(negedge pllclk);
		reset = 1'b1;
		for (int s = 0; s < NUM_STEPS; s++) begin
			if (STEPS[s].clr) begin
				pulse_clear();
			end
			for (int r = 0; r < STEPS[s].reps; r++) begin
				if (STEPS[s].rnd) begin
					lcg_state = lcg_next(lcg_state);
					bus = lcg_state[31:24];
				end else begin
					bus = {2'(STEPS[s].s3), 2'(STEPS[s].s2), 2'(STEPS[s].s1), 2'(STEPS[s].s0)};
				end
				apply_strobe(bus);
			end
			// full address space including the unused top
			for (int addr = 0; addr < 2 ** ADDR_WIDTH; addr++) begin
				read_and_check(addr);
			end
		end
		$display("TEST PASS");
		$finish;
	end

	initial begin
		int limit;
		limit = 20;
		for (int s = 0; s < NUM_STEPS; s++) begin
			limit += 3 * STEPS[s].reps + 2 * (2 ** ADDR_WIDTH) + 4;
		end
		repeat (2 * limit) @(posedge pllclk);
		stop_with_failure("timeout, the run did not finish in the expected time");
	end

endmodule

//--- design/correlator_top.sv
//**************************************************
// correlator top, core plus count readout
//**************************************************

module correlator_top #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS,
	parameter int SAMPLE_WIDTH = corr_cfg_pkg::DEF_SAMPLE_WIDTH,
	parameter int NUM_LAGS = corr_cfg_pkg::DEF_NUM_LAGS,
	parameter int ACC_WIDTH = corr_cfg_pkg::DEF_ACC_WIDTH
) (
	input logic pllclk,
	input logic reset,
	input logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] samples,
	input logic smpclk,
	input logic clear,
	input logic [corr_cfg_pkg::addr_width(NUM_INPUTS, NUM_LAGS)-1:0] rd_addr,
	input logic rd_strobe,
	output logic signed [ACC_WIDTH-1:0] rd_real,
	output logic signed [ACC_WIDTH-1:0] rd_imag,
	output logic rd_overflow,
	output logic rd_valid
);

	import corr_cfg_pkg::*;

	localparam int COUNTS = num_counts(NUM_INPUTS, NUM_LAGS);

	logic [COUNTS*ACC_WIDTH-1:0] real_counts;
	logic [COUNTS*ACC_WIDTH-1:0] imag_counts;
	logic [COUNTS-1:0] overflow_flags;

	correlator_core #(
		.NUM_INPUTS(NUM_INPUTS),
		.SAMPLE_WIDTH(SAMPLE_WIDTH),
		.NUM_LAGS(NUM_LAGS),
		.ACC_WIDTH(ACC_WIDTH)
	) u_core (
		.pllclk(pllclk),
		.reset(reset),
		.clear(clear),
		.smpclk(smpclk),
		.samples(samples),
		.real_counts(real_counts),
		.imag_counts(imag_counts),
		.overflow_flags(overflow_flags)
	);

	count_readout #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_LAGS(NUM_LAGS),
		.ACC_WIDTH(ACC_WIDTH)
	) u_readout (
		.pllclk(pllclk),
		.reset(reset),
		.rd_addr(rd_addr),
		.rd_strobe(rd_strobe),
		.real_counts(real_counts),
		.imag_counts(imag_counts),
		.overflow_flags(overflow_flags),
		.rd_real(rd_real),
		.rd_imag(rd_imag),
		.rd_overflow(rd_overflow),
		.rd_valid(rd_valid)
	);

endmodule

//--- design/count_readout.sv
//**************************************************
// addressed, registered readout of one lag's counts
//**************************************************

module count_readout #(
	parameter int NUM_INPUTS = 4,
	parameter int NUM_LAGS = 3,
	parameter int ACC_WIDTH = 12
) (
	input logic pllclk,
	input logic reset,
	input logic [corr_cfg_pkg::addr_width(NUM_INPUTS, NUM_LAGS)-1:0] rd_addr,
	input logic rd_strobe,
	input logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)*ACC_WIDTH-1:0] real_counts,
	input logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)*ACC_WIDTH-1:0] imag_counts,
	input logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)-1:0] overflow_flags,
	output logic signed [ACC_WIDTH-1:0] rd_real,
	output logic signed [ACC_WIDTH-1:0] rd_imag,
	output logic rd_overflow,
	output logic rd_valid
);

	import corr_cfg_pkg::*;

	localparam int COUNTS = num_counts(NUM_INPUTS, NUM_LAGS);

	logic addr_ok;

	assign addr_ok = int'(rd_addr) < COUNTS;

	// data holds its last value between reads
	always_ff @(posedge pllclk) begin
		if (rd_strobe) begin
			if (addr_ok) begin
				rd_real <= real_counts[rd_addr*ACC_WIDTH +: ACC_WIDTH];
				rd_imag <= imag_counts[rd_addr*ACC_WIDTH +: ACC_WIDTH];
				rd_overflow <= overflow_flags[rd_addr];
			end else begin
				rd_real <= '0;
				rd_imag <= '0;
				rd_overflow <= 1'b0;
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_strobe;
		end
	end

endmodule

//--- design/correlator_core.sv
//**************************************************
// per-input delay lines and per-lag accumulators
//**************************************************

module correlator_core #(
	parameter int NUM_INPUTS = 4,
	parameter int SAMPLE_WIDTH = 2,
	parameter int NUM_LAGS = 3,
	parameter int ACC_WIDTH = 12
) (
	input logic pllclk,
	input logic reset,
	input logic clear,
	input logic smpclk,
	input logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] samples,
	output logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)*ACC_WIDTH-1:0] real_counts,
	output logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)*ACC_WIDTH-1:0] imag_counts,
	output logic [corr_cfg_pkg::num_counts(NUM_INPUTS, NUM_LAGS)-1:0] overflow_flags
);

	import corr_data_pkg::*;

	// extra tap feeds the quadrature product of the last lag
	localparam int DEPTH = NUM_LAGS + 1;

	logic [DEPTH*SAMPLE_WIDTH-1:0] line_taps [NUM_INPUTS];
	logic taps_new;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		// all lines share smpclk, so line 0 times every accumulator
		if (i == 0) begin : g_lead
			sample_delay_line #(
				.SAMPLE_WIDTH(SAMPLE_WIDTH),
				.DEPTH(DEPTH)
			) u_line (
				.pllclk(pllclk),
				.reset(reset),
				.clear(clear),
				.smpclk(smpclk),
				.sample(samples[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
				.taps(line_taps[i]),
				.shifted(taps_new)
			);
		end else begin : g_follow
			sample_delay_line #(
				.SAMPLE_WIDTH(SAMPLE_WIDTH),
				.DEPTH(DEPTH)
			) u_line (
				.pllclk(pllclk),
				.reset(reset),
				.clear(clear),
				.smpclk(smpclk),
				.sample(samples[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
				.taps(line_taps[i]),
				.shifted()
			);
		end
	end

	for (genvar a = 0; a < NUM_INPUTS - 1; a++) begin : g_ref
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_pair
			for (genvar k = 0; k < NUM_LAGS; k++) begin : g_lag
				localparam int ADDR = count_address(a, b, k, NUM_INPUTS, NUM_LAGS);

				// newest sample of a against b, k and k+1 strobes back
				lag_accumulator #(
					.SAMPLE_WIDTH(SAMPLE_WIDTH),
					.ACC_WIDTH(ACC_WIDTH)
				) u_acc (
					.pllclk(pllclk),
					.reset(reset),
					.clear(clear),
					.shifted(taps_new),
					.ref_sample(line_taps[a][0 +: SAMPLE_WIDTH]),
					.lag_sample(line_taps[b][k*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
					.quad_sample(line_taps[b][(k+1)*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
					.real_count(real_counts[ADDR*ACC_WIDTH +: ACC_WIDTH]),
					.imag_count(imag_counts[ADDR*ACC_WIDTH +: ACC_WIDTH]),
					.overflow(overflow_flags[ADDR])
				);
			end
		end
	end

endmodule

//--- design/lag_accumulator.sv
//**************************************************
// real and quadrature MAC for one baseline and lag
//**************************************************

module lag_accumulator #(
	parameter int SAMPLE_WIDTH = 2,
	parameter int ACC_WIDTH = 12
) (
	input logic pllclk,
	input logic reset,
	input logic clear,
	input logic shifted,
	input logic signed [SAMPLE_WIDTH-1:0] ref_sample,
	input logic signed [SAMPLE_WIDTH-1:0] lag_sample,
	input logic signed [SAMPLE_WIDTH-1:0] quad_sample,
	output logic signed [ACC_WIDTH-1:0] real_count,
	output logic signed [ACC_WIDTH-1:0] imag_count,
	output logic overflow
);

	import corr_data_pkg::*;

	localparam int PROD_WIDTH = 2 * SAMPLE_WIDTH;
	// one guard bit over whichever operand is wider
	localparam int SUM_WIDTH = ((ACC_WIDTH > PROD_WIDTH) ? ACC_WIDTH : PROD_WIDTH) + 1;
	localparam longint ACC_HI = acc_max(ACC_WIDTH);
	localparam longint ACC_LO = acc_min(ACC_WIDTH);

	logic signed [PROD_WIDTH-1:0] real_prod;
	logic signed [PROD_WIDTH-1:0] imag_prod;
	logic signed [SUM_WIDTH-1:0] trial_real;
	logic signed [SUM_WIDTH-1:0] trial_imag;
	logic out_of_range;

	assign real_prod = ref_sample * lag_sample;
	assign imag_prod = ref_sample * quad_sample;

	assign trial_real = SUM_WIDTH'(real_count) + SUM_WIDTH'(real_prod);
	assign trial_imag = SUM_WIDTH'(imag_count) + SUM_WIDTH'(imag_prod);

	// either count leaving range freezes both
	assign out_of_range = (trial_real > ACC_HI) || (trial_real < ACC_LO) ||
		(trial_imag > ACC_HI) || (trial_imag < ACC_LO);

	always_ff @(posedge pllclk) begin
		if (!reset || clear) begin
			real_count <= '0;
			imag_count <= '0;
			overflow <= 1'b0;
		end else if (shifted && !overflow) begin
			if (out_of_range) begin
				overflow <= 1'b1;
			end else begin
				real_count <= trial_real[ACC_WIDTH-1:0];
				imag_count <= trial_imag[ACC_WIDTH-1:0];
			end
		end
	end

endmodule

//--- design/sample_delay_line.sv
//**************************************************
// tapped sample shift register, advanced on strobe
//**************************************************

module sample_delay_line #(
	parameter int SAMPLE_WIDTH = 2,
	parameter int DEPTH = 4
) (
	input logic pllclk,
	input logic reset,
	input logic clear,
	input logic smpclk,
	input logic signed [SAMPLE_WIDTH-1:0] sample,
	output logic [DEPTH*SAMPLE_WIDTH-1:0] taps,
	output logic shifted
);

	// tap 0 sits in the low bits, older samples above it
	always_ff @(posedge pllclk) begin
		if (!reset || clear) begin
			taps <= '0;
		end else if (smpclk) begin
			taps <= {taps[(DEPTH-1)*SAMPLE_WIDTH-1:0], sample};
		end
	end

	// taps are new one cycle after the strobe
	always_ff @(posedge pllclk) begin
		if (!reset || clear) begin
			shifted <= 1'b0;
		end else begin
			shifted <= smpclk;
		end
	end

endmodule

//--- design/corr_data_pkg.sv
//**************************************************
// count address layout and accumulator limits
//**************************************************

package corr_data_pkg;

	// pairs (0,1),(0,2)..(0,n-1),(1,2).. numbered row by row
	function automatic int baseline_index(input int a, input int b, input int num_inputs);
		return a * num_inputs - a * (a + 1) / 2 + (b - a - 1);
	endfunction

	function automatic int count_address(input int a, input int b, input int lag,
			input int num_inputs, input int num_lags);
		return baseline_index(a, b, num_inputs) * num_lags + lag;
	endfunction

	function automatic longint acc_max(input int width);
		return (longint'(1) <<< (width - 1)) - 1;
	endfunction

	function automatic longint acc_min(input int width);
		return -(longint'(1) <<< (width - 1));
	endfunction

endpackage

//--- design/corr_cfg_pkg.sv
//**************************************************
// default correlator sizes and count width helpers
//**************************************************

package corr_cfg_pkg;

	parameter int DEF_NUM_INPUTS = 4;
	parameter int DEF_SAMPLE_WIDTH = 2;
	parameter int DEF_NUM_LAGS = 3;
	parameter int DEF_ACC_WIDTH = 12;

	// one baseline per unordered input pair
	function automatic int num_baselines(input int num_inputs);
		return num_inputs * (num_inputs - 1) / 2;
	endfunction

	function automatic int num_counts(input int num_inputs, input int num_lags);
		return num_baselines(num_inputs) * num_lags;
	endfunction

	// at least one bit even for a single count
	function automatic int addr_width(input int num_inputs, input int num_lags);
		int total;
		total = num_counts(num_inputs, num_lags);
		return (total > 1) ? $clog2(total) : 1;
	endfunction

endpackage
